//--- sd_frame_pkg.sv
package sd_frame_pkg;

    // ==================================================
    // Frame geometry
    // ==================================================

    // Whole command or response frame on the CMD line
    localparam int FRAME_BITS = 48;

    // Start bit, direction bit, index and argument
    localparam int PAYLOAD_BITS = 40;

    localparam int CRC_BITS = 7;

    // Field positions inside a frame word
    localparam int PAYLOAD_LSB = 8;
    localparam int CRC_MSB     = 7;
    localparam int CRC_LSB     = 1;
    localparam int END_POS     = 0;

    // Bit counter wide enough to index one frame
    localparam int CNT_BITS = $clog2(FRAME_BITS);

    // CRC7 taps for x^7 + x^3 + 1
    localparam logic [CRC_BITS-1:0] CRC7_POLY = 7'h09;

    typedef logic [FRAME_BITS-1:0] frame_t;
    typedef logic [CNT_BITS-1:0]   cnt_t;

endpackage

//--- sd_resp_pkg.sv
package sd_resp_pkg;

    // ==================================================
    // Response handling
    // ==================================================

    // Response expected after a command
    typedef enum logic {
        RESP_NONE = 1'b0,
        RESP_48   = 1'b1
    } resp_type_t;

    // Cycles the receiver ignores CMD after the line is released
    localparam int TURNAROUND_CYCLES = 2;

    localparam int TURN_BITS = $clog2(TURNAROUND_CYCLES + 1);

    typedef logic [TURN_BITS-1:0] turn_cnt_t;

endpackage

//--- sd_crc7.sv
module sd_crc7 (
    input  logic                               clk_int,
    input  logic                               init_rstPulse,
    input  logic                               clear,
    input  logic                               enable,
    input  logic                               bit_in,
    output logic [sd_frame_pkg::CRC_BITS-1:0]  crc
);

    logic feedback;

    // Incoming bit against the register MSB
    assign feedback = bit_in ^ crc[sd_frame_pkg::CRC_BITS-1];

    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (enable) begin
            if (feedback) begin
                crc <= {crc[sd_frame_pkg::CRC_BITS-2:0], 1'b0} ^ sd_frame_pkg::CRC7_POLY;
            end else begin
                crc <= {crc[sd_frame_pkg::CRC_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

//--- sd_cmd_sequencer.sv
module sd_cmd_sequencer (
    input  logic                      clk_int,
    input  logic                      init_rstPulse,
    input  logic                      cmd_trigger,
    input  sd_frame_pkg::frame_t      cmd_data,
    input  sd_resp_pkg::resp_type_t   cmd_resp_type,
    input  logic                      tx_end,
    input  logic                      resp_done,
    output logic                      tx_start,
    output sd_frame_pkg::frame_t      tx_frame,
    output logic                      cmd_done,
    output logic                      rx_arm
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SEND,
        SEQ_WAIT_RESP
    } seq_state_t;

    seq_state_t              state;
    sd_resp_pkg::resp_type_t resp_type_q;
    logic                    accept;

    // Triggers while busy are dropped
    assign accept = cmd_trigger && (state == SEQ_IDLE);

    // ==================================================
    // Sequencing FSM
    // ==================================================
    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            state    <= SEQ_IDLE;
            tx_start <= 1'b0;
        end else begin
            tx_start <= accept;
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        state <= SEQ_SEND;
                    end
                end
                SEQ_SEND: begin
                    if (tx_end) begin
                        if (resp_type_q == sd_resp_pkg::RESP_48) begin
                            state <= SEQ_WAIT_RESP;
                        end else begin
                            state <= SEQ_IDLE;
                        end
                    end
                end
                SEQ_WAIT_RESP: begin
                    if (resp_done) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Command and response type held for the whole transaction
    always_ff @(posedge clk_int) begin
        if (accept) begin
            tx_frame    <= cmd_data;
            resp_type_q <= cmd_resp_type;
        end
    end

    assign cmd_done = tx_end && (state == SEQ_SEND);
    assign rx_arm   = cmd_done && (resp_type_q == sd_resp_pkg::RESP_48);

endmodule

//--- sd_cmd_serializer.sv
module sd_cmd_serializer (
    input  logic                  clk_int,
    input  logic                  init_rstPulse,
    input  logic                  tx_start,
    input  sd_frame_pkg::frame_t  tx_frame,
    output logic                  sd_cmd_out,
    output logic                  sd_cmd_oe,
    output logic                  tx_end
);

    sd_frame_pkg::frame_t                shreg;
    sd_frame_pkg::cnt_t                  bit_cnt;
    logic                                active;
    logic                                in_payload;
    logic                                at_crc;
    logic                                at_last;
    logic [sd_frame_pkg::CRC_BITS-1:0]   crc;

    assign in_payload = bit_cnt < sd_frame_pkg::cnt_t'(sd_frame_pkg::PAYLOAD_BITS);
    assign at_crc     = bit_cnt == sd_frame_pkg::cnt_t'(sd_frame_pkg::PAYLOAD_BITS);
    assign at_last    = bit_cnt == sd_frame_pkg::cnt_t'(sd_frame_pkg::FRAME_BITS - 1);

    // CRC over the payload bits as they leave
    sd_crc7 u_crc7 (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .clear         (tx_start),
        .enable        (active && in_payload),
        .bit_in        (shreg[sd_frame_pkg::FRAME_BITS-1]),
        .crc           (crc)
    );

    // ==================================================
    // Bit counter and line drive
    // ==================================================
    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            active     <= 1'b0;
            bit_cnt    <= '0;
            sd_cmd_out <= 1'b1;
            sd_cmd_oe  <= 1'b0;
            tx_end     <= 1'b0;
        end else begin
            // Fires once, in the cycle after the final bit
            tx_end <= sd_cmd_oe && !active;
            if (tx_start) begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end else if (active) begin
                sd_cmd_oe  <= 1'b1;
                bit_cnt    <= bit_cnt + 1'b1;
                // First CRC bit comes straight from the accumulator
                sd_cmd_out <= at_crc ? crc[sd_frame_pkg::CRC_BITS-1]
                                     : shreg[sd_frame_pkg::FRAME_BITS-1];
                if (at_last) begin
                    active <= 1'b0;
                end
            end else begin
                sd_cmd_oe  <= 1'b0;
                sd_cmd_out <= 1'b1;
            end
        end
    end

    // Shift path; trailing ones supply the end bit
    always_ff @(posedge clk_int) begin
        if (tx_start) begin
            shreg <= {tx_frame[sd_frame_pkg::FRAME_BITS-1:sd_frame_pkg::PAYLOAD_LSB],
                      {sd_frame_pkg::PAYLOAD_LSB{1'b1}}};
        end else if (active && at_crc) begin
            shreg <= {crc[sd_frame_pkg::CRC_BITS-2:0],
                      {(sd_frame_pkg::FRAME_BITS - sd_frame_pkg::CRC_BITS + 1){1'b1}}};
        end else if (active) begin
            shreg <= {shreg[sd_frame_pkg::FRAME_BITS-2:0], 1'b1};
        end
    end

endmodule

//--- sd_resp_receiver.sv
module sd_resp_receiver (
    input  logic                  clk_int,
    input  logic                  init_rstPulse,
    input  logic                  rx_arm,
    input  logic                  sd_cmd_in,
    output logic                  resp_done,
    output sd_frame_pkg::frame_t  resp_data,
    output logic                  resp_crc_err
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_TURN,
        RX_WAIT,
        RX_SHIFT,
        RX_CHECK
    } rx_state_t;

    rx_state_t                           state;
    sd_resp_pkg::turn_cnt_t              turn_cnt;
    sd_frame_pkg::cnt_t                  bit_cnt;
    sd_frame_pkg::frame_t                shreg;
    logic                                cmd_in_q;
    logic                                start_seen;
    logic                                crc_en;
    logic                                crc_bad;
    logic [sd_frame_pkg::CRC_BITS-1:0]   crc;

    // Single input register on the CMD line
    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            cmd_in_q <= 1'b1;
        end else begin
            cmd_in_q <= sd_cmd_in;
        end
    end

    assign start_seen = (state == RX_WAIT) && !cmd_in_q;

    // CRC runs over the start bit and the next 39
    always_comb begin
        crc_en = start_seen;
        if (state == RX_SHIFT &&
            bit_cnt < sd_frame_pkg::cnt_t'(sd_frame_pkg::PAYLOAD_BITS)) begin
            crc_en = 1'b1;
        end
    end

    sd_crc7 u_crc7 (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .clear         (rx_arm),
        .enable        (crc_en),
        .bit_in        (cmd_in_q),
        .crc           (crc)
    );

    assign crc_bad = (shreg[sd_frame_pkg::CRC_MSB:sd_frame_pkg::CRC_LSB] != crc) ||
                     !shreg[sd_frame_pkg::END_POS];

    // ==================================================
    // Receive FSM
    // ==================================================
    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            state        <= RX_IDLE;
            turn_cnt     <= '0;
            bit_cnt      <= '0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_arm) begin
                        turn_cnt <= sd_resp_pkg::turn_cnt_t'(sd_resp_pkg::TURNAROUND_CYCLES - 1);
                        state    <= RX_TURN;
                    end
                end
                RX_TURN: begin
                    if (turn_cnt == '0) begin
                        state <= RX_WAIT;
                    end else begin
                        turn_cnt <= turn_cnt - 1'b1;
                    end
                end
                RX_WAIT: begin
                    if (start_seen) begin
                        bit_cnt <= sd_frame_pkg::cnt_t'(1);
                        state   <= RX_SHIFT;
                    end
                end
                RX_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == sd_frame_pkg::cnt_t'(sd_frame_pkg::FRAME_BITS - 1)) begin
                        state <= RX_CHECK;
                    end
                end
                RX_CHECK: begin
                    resp_crc_err <= crc_bad;
                    resp_done    <= 1'b1;
                    state        <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Data path, MSB first
    always_ff @(posedge clk_int) begin
        if (start_seen || state == RX_SHIFT) begin
            shreg <= {shreg[sd_frame_pkg::FRAME_BITS-2:0], cmd_in_q};
        end
        if (state == RX_CHECK) begin
            resp_data <= shreg;
        end
    end

endmodule

//--- sd_cmd_ctrl.sv
module sd_cmd_ctrl (
    input  logic                      clk_int,
    input  logic                      init_rstPulse,

    // Host command side
    input  logic                      cmd_trigger,
    input  sd_frame_pkg::frame_t      cmd_data,
    input  sd_resp_pkg::resp_type_t   cmd_resp_type,
    output logic                      cmd_done,

    // Host response side
    output logic                      resp_done,
    output sd_frame_pkg::frame_t      resp_data,
    output logic                      resp_crc_err,

    // CMD pin, split into out, enable and in
    output logic                      sd_cmd_out,
    output logic                      sd_cmd_oe,
    input  logic                      sd_cmd_in
);

    logic                  tx_start;
    logic                  tx_end;
    logic                  rx_arm;
    sd_frame_pkg::frame_t  tx_frame;

    // ==================================================
    // Decode, execute, result
    // ==================================================
    sd_cmd_sequencer u_sequencer (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .cmd_trigger   (cmd_trigger),
        .cmd_data      (cmd_data),
        .cmd_resp_type (cmd_resp_type),
        .tx_end        (tx_end),
        .resp_done     (resp_done),
        .tx_start      (tx_start),
        .tx_frame      (tx_frame),
        .cmd_done      (cmd_done),
        .rx_arm        (rx_arm)
    );

    sd_cmd_serializer u_serializer (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .tx_start      (tx_start),
        .tx_frame      (tx_frame),
        .sd_cmd_out    (sd_cmd_out),
        .sd_cmd_oe     (sd_cmd_oe),
        .tx_end        (tx_end)
    );

    sd_resp_receiver u_receiver (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .rx_arm        (rx_arm),
        .sd_cmd_in     (sd_cmd_in),
        .resp_done     (resp_done),
        .resp_data     (resp_data),
        .resp_crc_err  (resp_crc_err)
    );

endmodule

//--- sd_cmd_ctrl_chk.sv
module sd_cmd_ctrl_chk (
    input logic clk_int,
    input logic init_rstPulse,
    input logic cmd_done,
    input logic resp_done,
    input logic sd_cmd_out,
    input logic sd_cmd_oe
);

    // Number of assertion failures so far
    int fail_count = 0;

    // ==================================================
    // Strobes
    // ==================================================
    a_cmd_done_pulse: assert property (@(posedge clk_int) disable iff (init_rstPulse)
        cmd_done |=> !cmd_done)
        else begin
            $error("cmd_done stayed high for more than one cycle");
            fail_count++;
        end

    a_resp_done_pulse: assert property (@(posedge clk_int) disable iff (init_rstPulse)
        resp_done |=> !resp_done)
        else begin
            $error("resp_done stayed high for more than one cycle");
            fail_count++;
        end

    // ==================================================
    // CMD line
    // ==================================================
    // One frame is at most 48 enabled cycles
    a_oe_length: assert property (@(posedge clk_int) disable iff (init_rstPulse)
        sd_cmd_oe [*48] |=> !sd_cmd_oe)
        else begin
            $error("sd_cmd_oe stayed high longer than one frame");
            fail_count++;
        end

    a_idle_high: assert property (@(posedge clk_int) disable iff (init_rstPulse)
        !sd_cmd_oe |-> sd_cmd_out)
        else begin
            $error("sd_cmd_out low while the line is released");
            fail_count++;
        end

endmodule

bind sd_cmd_ctrl sd_cmd_ctrl_chk u_chk (
    .clk_int       (clk_int),
    .init_rstPulse (init_rstPulse),
    .cmd_done      (cmd_done),
    .resp_done     (resp_done),
    .sd_cmd_out    (sd_cmd_out),
    .sd_cmd_oe     (sd_cmd_oe)
);

//--- tb_sd_cmd_ctrl.sv
module tb_sd_cmd_ctrl;

    localparam int          NUM_TXN      = 60;
    localparam int          TXN_CYCLES   = 150;
    localparam int          RESET_CYCLES = 8;
    localparam int          CYCLE_LIMIT  = RESET_CYCLES + NUM_TXN * TXN_CYCLES;
    localparam logic [31:0] LFSR_SEED    = 32'd99837;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic                    clk_int;
    logic                    init_rstPulse;
    logic                    cmd_trigger;
    sd_frame_pkg::frame_t    cmd_data;
    sd_resp_pkg::resp_type_t cmd_resp_type;
    logic                    cmd_done;
    logic                    resp_done;
    sd_frame_pkg::frame_t    resp_data;
    logic                    resp_crc_err;
    logic                    sd_cmd_out;
    logic                    sd_cmd_oe;
    logic                    sd_cmd_in;

    logic [31:0] lfsr;
    int          cycle_cnt;

    sd_cmd_ctrl uut (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .cmd_trigger   (cmd_trigger),
        .cmd_data      (cmd_data),
        .cmd_resp_type (cmd_resp_type),
        .cmd_done      (cmd_done),
        .resp_done     (resp_done),
        .resp_data     (resp_data),
        .resp_crc_err  (resp_crc_err),
        .sd_cmd_out    (sd_cmd_out),
        .sd_cmd_oe     (sd_cmd_oe),
        .sd_cmd_in     (sd_cmd_in)
    );

    always #10 clk_int = ~clk_int;

    // ==================================================
    // Random source and reference model
    // ==================================================

    // Galois LFSR stepped once per bit taken
    function automatic logic [47:0] take_bits(input int n);
        logic [47:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr[0]) begin
                lfsr = (lfsr >> 1) ^ LFSR_TAPS;
            end else begin
                lfsr = lfsr >> 1;
            end
            val = {val[46:0], lfsr[0]};
        end
        return val;
    endfunction

    // CRC7 over x^7 + x^3 + 1 taken MSB first from zero
    function automatic logic [6:0] crc7_model(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'b000_1001;
            end
        end
        return c;
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input logic [47:0] got, input logic [47:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("Error at %0t: %s, got %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_int);
        cycle_cnt++;
        if (uut.u_chk.fail_count != 0) begin
            stop_on_failure("A bound assertion on the CMD interface failed");
        end
        if (cycle_cnt > CYCLE_LIMIT) begin
            stop_on_failure("Timeout: the DUT stopped making progress before the run finished");
        end
    endtask

    // ==================================================
    // One command and the card's answer when asked
    // ==================================================
    task automatic run_transaction(input int idx);
        sd_frame_pkg::frame_t cmd_word;
        sd_frame_pkg::frame_t resp_word;
        sd_frame_pkg::frame_t captured;
        logic [47:0]          rnd;
        logic [39:0]          body;
        logic                 want_resp;
        logic [1:0]           kind;
        int                   gap;
        int                   flip;

        cmd_word  = take_bits(48);
        rnd       = take_bits(1);
        want_resp = rnd[0];
        rnd       = take_bits(2);
        kind      = rnd[1:0];
        rnd       = take_bits(3);
        gap       = 3 + int'(rnd[2:0]) % 7;
        rnd       = take_bits(3);
        flip      = 1 + int'(rnd[2:0]) % 7;
        rnd       = take_bits(39);
        body      = {1'b0, rnd[38:0]};

        // Clean, CRC flip and bad end bit up front
        if (idx < 3) begin
            want_resp = 1'b1;
            kind      = (idx == 0) ? 2'd0 : 2'(idx + 1);
        end

        resp_word = {body, crc7_model(body), 1'b1};
        if (kind == 2'd2) begin
            resp_word[flip] = ~resp_word[flip];
        end else if (kind == 2'd3) begin
            resp_word[0] = 1'b0;
        end

        next_cycle();
        cmd_trigger   <= 1'b1;
        cmd_data      <= cmd_word;
        cmd_resp_type <= want_resp ? sd_resp_pkg::RESP_48 : sd_resp_pkg::RESP_NONE;
        next_cycle();
        cmd_trigger   <= 1'b0;

        while (!sd_cmd_oe) begin
            next_cycle();
        end
        captured[47] = sd_cmd_out;
        for (int i = 46; i >= 0; i--) begin
            next_cycle();
            check_value(sd_cmd_oe, 1'b1, "sd_cmd_oe dropped inside the frame");
            captured[i] = sd_cmd_out;
        end
        next_cycle();
        check_value(sd_cmd_oe, 1'b0, "sd_cmd_oe after 48 bits");
        check_value(cmd_done, 1'b1, "cmd_done after the last bit");
        check_value(captured, {cmd_word[47:8], crc7_model(cmd_word[47:8]), 1'b1},
                    "command frame on CMD");

        if (want_resp) begin
            repeat (gap) begin
                next_cycle();
            end
            for (int i = 47; i >= 0; i--) begin
                sd_cmd_in <= resp_word[i];
                next_cycle();
            end
            sd_cmd_in <= 1'b1;
            while (!resp_done) begin
                next_cycle();
            end
            check_value(resp_data, resp_word, "resp_data");
            check_value(resp_crc_err, kind >= 2'd2, "resp_crc_err");
            next_cycle();
            check_value(resp_done, 1'b0, "resp_done pulsed twice");
        end else begin
            // No response phase expected
            repeat (20) begin
                next_cycle();
                check_value(resp_done, 1'b0, "resp_done without a response");
            end
        end
    endtask

    initial begin
        clk_int       = 1'b0;
        init_rstPulse = 1'b1;
        cmd_trigger   = 1'b0;
        cmd_data      = '0;
        cmd_resp_type = sd_resp_pkg::RESP_NONE;
        sd_cmd_in     = 1'b1;
        lfsr          = LFSR_SEED;
        cycle_cnt     = 0;

        // Known CMD0 frame CRC
        check_value(crc7_model(40'h40_0000_0000), 7'h4A, "CRC7 model on CMD0");

        repeat (RESET_CYCLES) begin
            next_cycle();
        end
        init_rstPulse <= 1'b0;

        repeat (5) begin
            next_cycle();
            check_value(sd_cmd_oe, 1'b0, "sd_cmd_oe before the first trigger");
            check_value(cmd_done, 1'b0, "cmd_done before the first trigger");
            check_value(resp_done, 1'b0, "resp_done before the first trigger");
        end

        for (int t = 0; t < NUM_TXN; t++) begin
            run_transaction(t);
        end

        // Half a cycle so the last edge's assertions have run
        @(negedge clk_int);
        if (uut.u_chk.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_failure("A bound assertion on the CMD interface failed");
        end
    end

endmodule

//--- sd_cmd_ctrl.f
sd_frame_pkg.sv
sd_resp_pkg.sv
sd_crc7.sv
sd_cmd_sequencer.sv
sd_cmd_serializer.sv
sd_resp_receiver.sv
sd_cmd_ctrl.sv
sd_cmd_ctrl_chk.sv
tb_sd_cmd_ctrl.sv

//--- Bender.yml
package:
  name: sd_cmd_ctrl

sources:
  - sd_frame_pkg.sv
  - sd_resp_pkg.sv
  - sd_crc7.sv
  - sd_cmd_sequencer.sv
  - sd_cmd_serializer.sv
  - sd_resp_receiver.sv
  - sd_cmd_ctrl.sv
  - target: test
    files:
      - sd_cmd_ctrl_chk.sv
      - tb_sd_cmd_ctrl.sv
